// ==== common/spi_pkg.sv ====
package spi_pkg;

	//////////////////////////////
	// divider code and bit order
	//////////////////////////////

	// spi_clk rate select, sck/4 up to sck/32
	typedef enum logic [1:0] {
		div4  = 2'b00,
		div8  = 2'b01,
		div16 = 2'b10,
		div32 = 2'b11
	} cdiv_t;

	// which end of the word goes on the wire first
	typedef enum logic {
		lsb_first = 1'b0,
		msb_first = 1'b1
	} bit_order_t;

	//////////////////////////////
	// divider lookup
	//////////////////////////////

	// sck cycles per spi_clk half period
	function automatic logic [4:0] half_period(input cdiv_t code);
		logic [4:0] hp;
		case (code)
			div4:    hp = 5'd2;
			div8:    hp = 5'd4;
			div16:   hp = 5'd8;
			div32:   hp = 5'd16;
			default: hp = 5'd16; // slowest, safe fallback
		endcase
		return hp;
	endfunction

endpackage

// ==== dv/spi_link_tb.sv ====
`timescale 1ns/100ps

module spi_link_tb;
	import spi_pkg::*;

	localparam int data_w   = 8;
	localparam int wait_lim = 2000; // sck cycles, slowest transfer is far below

	logic              sck = 1'b0;
	logic              clr;
	logic              start;
	cdiv_t             cdiv;
	bit_order_t        order;
	logic [data_w-1:0] tx_data;
	logic [data_w-1:0] slv_tx_data;
	logic [data_w-1:0] rx_data;
	logic              done;
	logic              busy;
	logic [data_w-1:0] slv_rx_data;
	logic              slv_done;
	logic              cs_n;
	logic              spi_clk;
	logic              mosi;
	logic              miso;

	int errors;
	int timeouts;
	int seed;

	spi_link_top #(.data_w(data_w)) u_dut (.*);

	initial begin
		forever #20 sck = ~sck; // 40 ns period
	end

	//////////////////////////////
	// compare and end of run
	//////////////////////////////

	task automatic check_word(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
	                          input string what);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			errors++;
			$display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic end_run();
		$display("errors: %0d  timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	// full spi_clk period in sck cycles, sck/4 up to sck/32
	function automatic int clk_period_for(input cdiv_t div);
		case (div)
			div4:    return 4;
			div8:    return 8;
			div16:   return 16;
			default: return 32;
		endcase
	endfunction

	//////////////////////////////
	// waits and transfer driver
	//////////////////////////////

	task automatic wait_slv_done();
		int cyc;
		cyc = 0;
		while (slv_done !== 1'b1) begin
			@(negedge sck);
			cyc++;
			if (cyc > wait_lim) begin
				timeouts++;
				$display("timeout: the slave never pulsed slv_done");
				end_run();
			end
		end
	endtask

	// one exchange, called on a falling sck edge; poke fires a start while busy
	task automatic xfer(input logic [data_w-1:0] mw, input logic [data_w-1:0] sw,
	                    input bit_order_t ord, input cdiv_t div, input bit poke);
		int                cyc;
		int                nrise;
		int                first_rise;
		int                second_rise;
		int                pos;
		logic              clk_prev;
		logic [data_w-1:0] mosi_word;
		logic [data_w-1:0] miso_word;
		start       = 1'b1;
		tx_data     = mw;
		slv_tx_data = sw;
		order       = ord;
		cdiv        = div;
		@(negedge sck);
		start = 1'b0;
		check_bit(busy, 1'b1, "busy after accept");
		cyc         = 0;
		nrise       = 0;
		first_rise  = 0;
		second_rise = 0;
		mosi_word   = '0;
		miso_word   = '0;
		clk_prev    = spi_clk;
		while (done !== 1'b1) begin
			@(negedge sck);
			cyc++;
			start = 1'b0;
			if (poke && cyc == 3) begin // mid transfer, must be ignored
				check_bit(busy, 1'b1, "busy before second start");
				start   = 1'b1;
				tx_data = ~mw;
			end
			if (spi_clk === 1'b1 && clk_prev === 1'b0) begin // spi_clk rose
				check_bit(cs_n, 1'b0, "cs_n at rising spi_clk");
				if (nrise < data_w) begin
					pos = (ord == msb_first) ? data_w - 1 - nrise : nrise; // arrival slot
					mosi_word[pos] = mosi;
					miso_word[pos] = miso;
				end
				if (nrise == 0)
					first_rise = cyc;
				if (nrise == 1)
					second_rise = cyc;
				nrise++;
			end
			clk_prev = spi_clk;
			if (cyc > wait_lim) begin
				timeouts++;
				$display("timeout: the master never pulsed done");
				end_run();
			end
		end
		check_count(nrise, data_w, "rising spi_clk edges per transfer");
		check_count(second_rise - first_rise, clk_period_for(div), "spi_clk period");
		check_word(rx_data, sw, "master rx_data");
		check_word(mosi_word, mw, "word rebuilt from mosi");
		check_word(miso_word, sw, "word rebuilt from miso");
		check_bit(cs_n, 1'b1, "cs_n released with done");
		wait_slv_done();
		check_word(slv_rx_data, mw, "slave slv_rx_data");
		check_bit(done, 1'b0, "done single pulse");
		check_bit(busy, 1'b0, "busy after done");
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic idle_checks(input string when);
		check_bit(cs_n, 1'b1, {"cs_n ", when});
		check_bit(spi_clk, 1'b1, {"spi_clk ", when});
		check_bit(mosi, 1'b1, {"mosi ", when});
		check_bit(miso, 1'b1, {"miso ", when});
		check_bit(done, 1'b0, {"done ", when});
		check_bit(slv_done, 1'b0, {"slv_done ", when});
		check_bit(busy, 1'b0, {"busy ", when});
		check_word(rx_data, '0, {"rx_data ", when});
		check_word(slv_rx_data, '0, {"slv_rx_data ", when});
	endtask

	task automatic test_reset_idle();
		clr = 1'b1;
		repeat (4) @(negedge sck);
		idle_checks("during reset");
		repeat (4) @(negedge sck); // 8 cycles in all
		clr = 1'b0;
		@(negedge sck);
		idle_checks("after reset");
	endtask

	task automatic test_bit_order();
		xfer(8'h1e, 8'hc4, msb_first, div8, 1'b0);
		xfer(8'h1e, 8'hc4, lsb_first, div8, 1'b0); // same words, reversed wire order
		xfer(8'h6b, 8'h90, lsb_first, div4, 1'b0);
	endtask

	task automatic test_divider();
		for (int i = 0; i < 4; i++)
			xfer(8'h5a, 8'hd3, msb_first, cdiv_t'(i), 1'b0);
	endtask

	task automatic test_start_busy();
		xfer(8'h37, 8'ha9, msb_first, div16, 1'b1);
		xfer(8'hc8, 8'h2f, lsb_first, div4, 1'b0); // fresh start right after
	endtask

	task automatic test_random();
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] m;
		for (int i = 0; i < 20; i++) begin
			m = $random(seed);
			s = $random(seed);
			r = $random(seed);
			xfer(m[data_w-1:0], s[data_w-1:0], bit_order_t'(r[0]), cdiv_t'(r[2:1]), 1'b0);
		end
	endtask

	initial begin
		errors      = 0;
		timeouts    = 0;
		seed        = 32'hc16e;
		clr         = 1'b1;
		start       = 1'b0;
		cdiv        = div4;
		order       = msb_first;
		tx_data     = '0;
		slv_tx_data = '0;
		test_reset_idle();
		xfer(8'ha5, 8'h3c, msb_first, div4, 1'b0); // basic exchange
		test_bit_order();
		test_divider();
		test_start_busy();
		test_random();
		end_run();
	end

endmodule

// ==== hw/spi_link_top.sv ====
`timescale 1ns/100ps

module spi_link_top #(
	parameter int data_w = 8
) (
	input  logic                sck,
	input  logic                clr,
	// master control side
	input  logic                start,
	input  spi_pkg::cdiv_t      cdiv,
	input  spi_pkg::bit_order_t order,
	input  logic [data_w-1:0]   tx_data,
	input  logic [data_w-1:0]   slv_tx_data,
	output logic [data_w-1:0]   rx_data,
	output logic                done,
	output logic                busy,
	// slave result side
	output logic [data_w-1:0]   slv_rx_data,
	output logic                slv_done,
	// serial pins, brought out for observation
	output logic                cs_n,
	output logic                spi_clk,
	output logic                mosi,
	output logic                miso
);

	//////////////////////////////
	// master
	//////////////////////////////

	spi_master #(.data_w(data_w)) u_master (
		.sck     (sck),
		.clr     (clr),
		.start   (start),
		.cdiv    (cdiv),
		.order   (order),
		.tx_data (tx_data),
		.miso    (miso),    // reply from slave
		.cs_n    (cs_n),
		.spi_clk (spi_clk),
		.mosi    (mosi),
		.rx_data (rx_data),
		.done    (done),
		.busy    (busy)
	);

	//////////////////////////////
	// slave
	//////////////////////////////

	spi_slave #(.data_w(data_w)) u_slave (
		.sck         (sck),
		.clr         (clr),
		.order       (order),   // both ends agree on bit order
		.cs_n        (cs_n),
		.spi_clk     (spi_clk),
		.mosi        (mosi),
		.slv_tx_data (slv_tx_data),
		.miso        (miso),
		.slv_rx_data (slv_rx_data),
		.slv_done    (slv_done)
	);

endmodule

// ==== hw/spi_master/spi_clk_gen.sv ====
`timescale 1ns/100ps

module spi_clk_gen (
	input  logic           sck,
	input  logic           clr,
	input  logic           en,      // high while bits are moving
	input  spi_pkg::cdiv_t cdiv,
	output logic           spi_clk,
	output logic           fall,    // spi_clk just went low
	output logic           rise     // spi_clk just went high
);
	import spi_pkg::*;

	logic [4:0] hp;  // half period length in sck cycles
	logic [4:0] cnt; // position inside current half period
	logic       tick;

	assign hp   = half_period(cdiv);
	assign tick = (cnt == hp - 5'd1); // last cycle of the half period

	//////////////////////////////
	// half period counter
	//////////////////////////////

	always_ff @(posedge sck or posedge clr) begin
		if (clr) begin
			cnt     <= 5'd0;
			spi_clk <= 1'b1; // mode 3 idles high
			fall    <= 1'b0;
			rise    <= 1'b0;
		end else if (!en) begin
			cnt     <= 5'd0;
			spi_clk <= 1'b1; // back to idle level
			fall    <= 1'b0;
			rise    <= 1'b0;
		end else if (tick) begin
			cnt     <= 5'd0;
			spi_clk <= ~spi_clk;
			// strobe lines up with the new spi_clk level
			fall    <= spi_clk;
			rise    <= ~spi_clk;
		end else begin
			cnt  <= cnt + 5'd1;
			fall <= 1'b0;
			rise <= 1'b0;
		end
	end

	// strobes are single cycle since tick
	// never repeats before hp >= 2 cycles

endmodule

// ==== hw/spi_master/spi_master.sv ====
`timescale 1ns/100ps

module spi_master #(
	parameter int data_w = 8
) (
	input  logic                sck,
	input  logic                clr,
	input  logic                start,   // one cycle pulse
	input  spi_pkg::cdiv_t      cdiv,
	input  spi_pkg::bit_order_t order,
	input  logic [data_w-1:0]   tx_data,
	input  logic                miso,
	output logic                cs_n,
	output logic                spi_clk,
	output logic                mosi,
	output logic [data_w-1:0]   rx_data,
	output logic                done,    // one cycle pulse
	output logic                busy
);
	import spi_pkg::*;

	localparam int cnt_w = $clog2(data_w + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_shift,
		st_finish
	} state_t;

	state_t            state;
	cdiv_t             cdiv_q;  // held for the whole transfer
	bit_order_t        order_q;
	logic [data_w-1:0] treg;    // transmit shifter
	logic [data_w-1:0] rreg;    // receive shifter
	logic [cnt_w-1:0]  nbit;    // rising edges seen
	logic [4:0]        wcnt;    // tail wait in finish
	logic              clk_en;
	logic              fall;
	logic              rise;
	logic              busy_core;
	logic              accept;
	logic              fin_end;
	logic              msb;

	assign busy_core = (state != st_idle) || done; // done cycle still counts as busy
	assign accept    = start && !busy_core;
	assign busy      = busy_core || accept;
	assign clk_en    = (state == st_shift);
	assign fin_end   = (state == st_finish) && (wcnt == half_period(cdiv_q) - 5'd1);
	assign msb       = (order_q == msb_first);

	spi_clk_gen u_clk_gen (
		.sck     (sck),
		.clr     (clr),
		.en      (clk_en),
		.cdiv    (cdiv_q),
		.spi_clk (spi_clk),
		.fall    (fall),
		.rise    (rise)
	);

	//////////////////////////////
	// transfer FSM
	//////////////////////////////

	always_ff @(posedge sck or posedge clr) begin
		if (clr) begin
			state   <= st_idle;
			cdiv_q  <= div4;
			order_q <= msb_first;
			nbit    <= '0;
			wcnt    <= 5'd0;
			cs_n    <= 1'b1;
			done    <= 1'b0;
			rx_data <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				st_idle: if (accept) begin
					state   <= st_shift;
					cdiv_q  <= cdiv;
					order_q <= order;
					nbit    <= '0;
					cs_n    <= 1'b0; // select one cycle after accept
				end
				st_shift: if (rise) begin
					nbit <= nbit + cnt_w'(1);
					if (nbit == cnt_w'(data_w - 1)) begin // last sample edge
						state <= st_finish;
						wcnt  <= 5'd0;
					end
				end
				st_finish: if (fin_end) begin
					state   <= st_idle;
					cs_n    <= 1'b1;
					done    <= 1'b1;
					rx_data <= rreg;
				end else begin
					wcnt <= wcnt + 5'd1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	//////////////////////////////
	// serial data path
	//////////////////////////////

	// first fall only repeats bit 0, shifting starts after a rise
	always_ff @(posedge sck or posedge clr) begin
		if (clr)
			mosi <= 1'b1;
		else if (accept)
			mosi <= (order == msb_first) ? tx_data[data_w-1] : tx_data[0];
		else if (fall && nbit != '0)
			mosi <= msb ? treg[data_w-2] : treg[1];
		else if (fin_end)
			mosi <= 1'b1; // release with cs_n
	end

	always_ff @(posedge sck) begin
		if (accept)
			treg <= tx_data;
		else if (fall && nbit != '0)
			treg <= msb ? {treg[data_w-2:0], 1'b1} : {1'b1, treg[data_w-1:1]}; // fill with ones
		if (rise)
			rreg <= msb ? {rreg[data_w-2:0], miso} : {miso, rreg[data_w-1:1]};
	end

endmodule

// ==== hw/spi_slave/spi_slave.sv ====
`timescale 1ns/100ps

module spi_slave #(
	parameter int data_w = 8
) (
	input  logic                sck,
	input  logic                clr,
	input  spi_pkg::bit_order_t order,
	input  logic                cs_n,
	input  logic                spi_clk,
	input  logic                mosi,
	input  logic [data_w-1:0]   slv_tx_data, // reply word
	output logic                miso,
	output logic [data_w-1:0]   slv_rx_data,
	output logic                slv_done
);
	import spi_pkg::*;

	logic              clk_q;    // spi_clk one cycle back
	logic              cs_q;     // cs_n one cycle back
	logic              clk_rise;
	logic              clk_fall;
	logic              cs_fall;
	logic              cs_rise;
	logic              got_rise; // a sample edge has passed
	logic              shift_out;
	bit_order_t        order_q;
	logic [data_w-1:0] reply;    // outgoing shifter
	logic [data_w-1:0] cap;      // incoming shifter

	//////////////////////////////
	// edge detection
	//////////////////////////////

	// same sck domain, one register is enough
	always_ff @(posedge sck or posedge clr) begin
		if (clr) begin
			clk_q <= 1'b1;
			cs_q  <= 1'b1;
		end else begin
			clk_q <= spi_clk;
			cs_q  <= cs_n;
		end
	end

	assign clk_rise  = spi_clk && !clk_q;
	assign clk_fall  = !spi_clk && clk_q;
	assign cs_fall   = !cs_n && cs_q;
	assign cs_rise   = cs_n && !cs_q;
	assign shift_out = !cs_n && clk_fall && got_rise; // skip the leading fall

	//////////////////////////////
	// control and miso
	//////////////////////////////

	always_ff @(posedge sck or posedge clr) begin
		if (clr) begin
			miso        <= 1'b1;
			slv_done    <= 1'b0;
			slv_rx_data <= '0;
			got_rise    <= 1'b0;
			order_q     <= msb_first;
		end else begin
			slv_done <= 1'b0;
			if (cs_fall) begin
				order_q  <= order;
				got_rise <= 1'b0;
				miso     <= (order == msb_first) ? slv_tx_data[data_w-1] : slv_tx_data[0];
			end else if (cs_rise) begin
				slv_rx_data <= cap;  // word complete
				slv_done    <= 1'b1;
				miso        <= 1'b1; // idle level
			end else if (!cs_n) begin
				if (clk_rise)
					got_rise <= 1'b1;
				if (shift_out)
					miso <= (order_q == msb_first) ? reply[data_w-2] : reply[1];
			end
		end
	end

	//////////////////////////////
	// shift registers
	//////////////////////////////

	always_ff @(posedge sck) begin
		if (cs_fall)
			reply <= slv_tx_data;
		else if (shift_out)
			reply <= (order_q == msb_first) ? {reply[data_w-2:0], 1'b1}
			                                : {1'b1, reply[data_w-1:1]};
		if (!cs_n && clk_rise) // sample mosi
			cap <= (order_q == msb_first) ? {cap[data_w-2:0], mosi} : {mosi, cap[data_w-1:1]};
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the SPI link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
	--top-module spi_link_tb -f spi_link_top.f -o spi_link_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/spi_link_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the testbench prints the pass line only when every check held
if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed"
exit 1

// ==== spi_link_top.f ====
common/spi_pkg.sv
hw/spi_master/spi_clk_gen.sv
hw/spi_master/spi_master.sv
hw/spi_slave/spi_slave.sv
hw/spi_link_top.sv
dv/spi_link_tb.sv
